//--- Makefile
TOP = tb_pifo_sched

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	@if grep -q "Verification failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "Verification passed" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_pifo_sched.sv
`timescale 1ns/1ns
`include "sched_consts.svh"

module tb_pifo_sched
    import sched_pkg::*;
();

    // tests take under 100 cycles, so this leaves a wide margin
    localparam int MAX_CYCLES = 500;

    logic                    clk;
    logic                    rstn;
    logic                    insert_en;
    elem_t                   in_elem;
    logic                    pop_en;
    logic                    cfg_we;
    logic [`COS_W-1:0]       cfg_class;
    logic                    cfg_pause;
    prank_t                  cfg_pause_rank;
    logic                    deq_valid;
    elem_t                   deq_elem;
    logic [`NUM_CLASSES-1:0] class_full;

    integer seed;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    int     cycles = 0;
    // model of the service order and of the last dequeued overflow bit
    elem_t  exp_q[$];
    logic   model_ovf = 1'b0;

    pifo_sched_top uut (.*);

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("run timed out after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual === expected)
            pass_cnt++;
        else
        begin
            fail_cnt++;
            $display("[ERROR] %0t: %s, got %0h expected %0h", $time, msg, actual, expected);
        end
    endtask

    function automatic elem_t make_elem(input logic ovf, input logic [`RANK_W-1:0] rank,
                                        input logic [`COS_W-1:0] cos, input prank_t gpfc,
                                        input logic [`ADDR_W-1:0] addr);
        elem_t e;
        e.overflow  = ovf;
        e.rank      = rank;
        e.cos       = cos;
        e.gpfc_rank = gpfc;
        e.addr      = addr;
        return e;
    endfunction

    // wrapped elements go last, then ascending rank
    function automatic logic comes_first(input elem_t a, input elem_t b, input logic lovf);
        logic a_wrap;
        logic b_wrap;
        a_wrap = (a.overflow != lovf);
        b_wrap = (b.overflow != lovf);
        if (a_wrap == b_wrap)
            return (a.rank <= b.rank);
        return b_wrap;
    endfunction

    // stable insert, so equal elements keep the order they were added in
    task automatic expect_insert(input elem_t e);
        int pos;
        pos = 0;
        while (pos < exp_q.size() && comes_first(exp_q[pos], e, model_ovf))
            pos++;
        exp_q.insert(pos, e);
    endtask

    // no pop on this edge, so deq_valid must be low afterwards
    task automatic insert(input elem_t e);
        in_elem   = e;
        insert_en = 1'b1;
        step();
        insert_en = 1'b0;
        check_value(32'(deq_valid), 32'd0, "deq_valid after insert");
    endtask

    task automatic set_pause(input logic [`COS_W-1:0] cls, input logic en, input prank_t thr);
        cfg_class      = cls;
        cfg_pause      = en;
        cfg_pause_rank = thr;
        cfg_we         = 1'b1;
        step();
        cfg_we = 1'b0;
    endtask

    task automatic pop_check(input elem_t exp_e, input string tag);
        pop_en = 1'b1;
        step();
        pop_en = 1'b0;
        check_value(32'(deq_valid), 32'd1, {tag, " deq_valid"});
        check_value(32'(deq_elem), 32'(exp_e), {tag, " deq_elem"});
        model_ovf = exp_e.overflow;
    endtask

    task automatic pop_model(input string tag);
        elem_t e;
        e = exp_q.pop_front();
        pop_check(e, tag);
    endtask

    task automatic pop_none(input string tag);
        pop_en = 1'b1;
        step();
        pop_en = 1'b0;
        check_value(32'(deq_valid), 32'd0, {tag, " deq_valid"});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        check_value(32'(deq_valid), 32'd0, "reset deq_valid");
        check_value(32'(class_full), 32'd0, "reset class_full");
        pop_none("empty pop");
        $display("test reset_state done, %0d errors so far", fail_cnt);
    endtask

    task automatic test_fill_class();
        logic [31:0] r;
        elem_t       e;
        for (int i = 0; i < `QUEUE_DEPTH; i++)
        begin
            check_value(32'(class_full[2]), 32'd0, "fill full early");
            r = $random(seed);
            e = make_elem(1'b0, r[7:0], 3'd2, 6'd0, 12'(12'h200 + i));
            insert(e);
            expect_insert(e);
        end
        check_value(32'(class_full[2]), 32'd1, "fill full");
        // rank 0 would come out first if it were taken
        insert(make_elem(1'b0, 8'd0, 3'd2, 6'd0, 12'h2ff));
        check_value(32'(class_full[2]), 32'd1, "fill full after extra insert");
        for (int i = 0; i < `QUEUE_DEPTH; i++)
            pop_model("fill pop");
        pop_none("fill drained");
        check_value(32'(class_full[2]), 32'd0, "fill full after drain");
        $display("test fill_class done, %0d errors so far", fail_cnt);
    endtask

    task automatic test_all_classes();
        logic [31:0] r;
        elem_t       e;
        for (int c = 0; c < `NUM_CLASSES; c++)
        begin
            r = $random(seed);
            e = make_elem(1'b0, r[7:0], `COS_W'(c), 6'd0, 12'(c << 8));
            insert(e);
            expect_insert(e);
        end
        for (int c = 0; c < `NUM_CLASSES; c++)
            pop_model("classes pop");
        pop_none("classes drained");
        $display("test all_classes done, %0d errors so far", fail_cnt);
    endtask

    task automatic test_pause();
        elem_t blocked;
        elem_t low_prank;
        elem_t other;
        blocked   = make_elem(1'b0, 8'd5, 3'd3, 6'd20, 12'h300);
        low_prank = make_elem(1'b0, 8'd1, 3'd3, 6'd5, 12'h301);
        other     = make_elem(1'b0, 8'd50, 3'd1, 6'd0, 12'h100);
        set_pause(3'd3, 1'b1, 6'd10);
        insert(blocked);
        insert(other);
        pop_check(other, "pause skip");
        insert(low_prank);
        pop_check(low_prank, "pause below threshold");
        pop_none("pause only blocked head");
        set_pause(3'd3, 1'b0, 6'd0);
        pop_check(blocked, "pause cleared");
        $display("test pause done, %0d errors so far", fail_cnt);
    endtask

    task automatic test_overflow_wrap();
        elem_t e;
        e = make_elem(1'b0, 8'd200, 3'd4, 6'd0, 12'h400);
        insert(e);
        expect_insert(e);
        e = make_elem(1'b1, 8'd3, 3'd5, 6'd0, 12'h500);
        insert(e);
        expect_insert(e);
        pop_model("wrap current first");
        pop_model("wrap overflow one");
        // last dequeued overflow bit is now 1
        e = make_elem(1'b0, 8'd3, 3'd6, 6'd0, 12'h600);
        insert(e);
        expect_insert(e);
        e = make_elem(1'b1, 8'd200, 3'd7, 6'd0, 12'h700);
        insert(e);
        expect_insert(e);
        pop_model("wrap reversed");
        pop_model("wrap reversed second");
        e = make_elem(1'b0, 8'd10, 3'd6, 6'd0, 12'h610);
        insert(e);
        expect_insert(e);
        e = make_elem(1'b0, 8'd40, 3'd6, 6'd0, 12'h640);
        insert(e);
        expect_insert(e);
        // pop and insert on the same edge, same class
        e = make_elem(1'b0, 8'd20, 3'd6, 6'd0, 12'h620);
        in_elem   = e;
        insert_en = 1'b1;
        pop_model("same cycle pop");
        insert_en = 1'b0;
        expect_insert(e);
        pop_model("same cycle new element");
        pop_model("same cycle last element");
        pop_none("wrap drained");
        $display("test overflow_wrap done, %0d errors so far", fail_cnt);
    endtask

    initial
    begin
        seed           = 32'h4965;
        clk            = 1'b0;
        rstn           = 1'b0;
        insert_en      = 1'b0;
        in_elem        = '0;
        pop_en         = 1'b0;
        cfg_we         = 1'b0;
        cfg_class      = '0;
        cfg_pause      = 1'b0;
        cfg_pause_rank = '0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_reset_state();
        test_fill_class();
        test_all_classes();
        test_pause();
        test_overflow_wrap();
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- src/class_pifo.sv
`timescale 1ns/1ns
`include "sched_consts.svh"

// rank-sorted queue for one traffic class, entry 0 is the head
module class_pifo
    import sched_pkg::*;
#(
    parameter int CLASS_ID = 0
)
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   ins,
    input  elem_t  ins_elem,
    head_if.queue  hq
);

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam logic [`CNT_W-1:0] DEPTH_CNT = `CNT_W'(`QUEUE_DEPTH);

    elem_t             entry [DEPTH];
    logic [`CNT_W-1:0] count;

    elem_t             shifted [DEPTH];
    elem_t             placed [DEPTH];
    logic [DEPTH-1:0]  keep;
    logic [`CNT_W-1:0] cnt_after_pop;
    logic              pop_ok;
    logic              ins_ok;

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        pop_ok = hq.pop[CLASS_ID] && (count != '0);

        // pop first, so a same-cycle insert sees the remaining entries
        for (int k = 0; k < DEPTH; k++)
        begin
            shifted[k] = entry[k];
        end
        if (pop_ok)
        begin
            for (int k = 0; k < DEPTH - 1; k++)
            begin
                shifted[k] = entry[k + 1];
            end
        end
        cnt_after_pop = count - `CNT_W'(pop_ok);
        ins_ok = ins && (cnt_after_pop != DEPTH_CNT);

        // entries that stay ahead of the new one, equal ranks keep arrival order
        for (int k = 0; k < DEPTH; k++)
        begin
            keep[k] = (`CNT_W'(k) < cnt_after_pop)
                      && elem_precedes(shifted[k], ins_elem, hq.last_ovf);
        end

        // first slot not kept takes the new element, the rest move down
        placed[0] = keep[0] ? shifted[0] : ins_elem;
        for (int k = 1; k < DEPTH; k++)
        begin
            if (keep[k])
                placed[k] = shifted[k];
            else if (keep[k - 1])
                placed[k] = ins_elem;
            else
                placed[k] = shifted[k - 1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            count <= '0;
        else
            count <= cnt_after_pop + `CNT_W'(ins_ok);
    end

    always_ff @(posedge clk)
    begin
        if (ins_ok)
            entry <= placed;
        else
            entry <= shifted;
    end

    assign hq.head_valid[CLASS_ID] = (count != '0);
    assign hq.head[CLASS_ID]       = entry[0];
    assign hq.full[CLASS_ID]       = (count == DEPTH_CNT);

    a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= DEPTH_CNT);

endmodule

//--- src/head_arbiter.sv
`timescale 1ns/1ns
`include "sched_consts.svh"

// picks the best eligible head over all classes on a pop strobe
module head_arbiter
    import sched_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    pop_en,
    input  logic [`NUM_CLASSES-1:0] pause_en,
    input  prank_t                  pause_rank [`NUM_CLASSES],
    head_if.arbiter                 ha,
    output logic                    deq_valid,
    output elem_t                   deq_elem
);

    localparam int N = `NUM_CLASSES;

    logic [N-1:0]       eligible;
    logic [N-1:0]       best;
    logic               found;
    logic [`COS_W-1:0]  win_idx;
    logic               take;
    elem_t              win_elem;

    ////////////////////////////////////////////////////////////////////////////
    // eligibility and cross-class compare
    ////////////////////////////////////////////////////////////////////////////

    // a paused class still passes heads below its threshold
    always_comb
    begin
        for (int c = 0; c < N; c++)
        begin
            eligible[c] = ha.head_valid[c]
                          && (!pause_en[c] || (ha.head[c].gpfc_rank < pause_rank[c]));
        end
    end

    // best[c] when no other eligible head beats c, lower index wins a tie
    always_comb
    begin
        for (int c = 0; c < N; c++)
        begin
            best[c] = eligible[c];
            for (int d = 0; d < N; d++)
            begin
                if ((d < c) && eligible[d]
                    && elem_precedes(ha.head[d], ha.head[c], ha.last_ovf))
                    best[c] = 1'b0;
                if ((d > c) && eligible[d]
                    && !elem_precedes(ha.head[c], ha.head[d], ha.last_ovf))
                    best[c] = 1'b0;
            end
        end
    end

    always_comb
    begin
        found   = 1'b0;
        win_idx = '0;
        for (int c = N - 1; c >= 0; c--)
        begin
            if (best[c])
            begin
                found   = 1'b1;
                win_idx = `COS_W'(c);
            end
        end
    end

    assign take     = pop_en && found;
    assign win_elem = ha.head[win_idx];
    assign ha.pop   = pop_en ? best : '0;

    ////////////////////////////////////////////////////////////////////////////
    // dequeue register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            deq_valid   <= 1'b0;
            ha.last_ovf <= 1'b0;
        end
        else
        begin
            deq_valid <= take;
            if (take)
                ha.last_ovf <= win_elem.overflow;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
            deq_elem <= win_elem;
    end

    a_pop_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(ha.pop));

    // queue side must hold a head for every pop it receives
    a_pop_valid: assert property (@(posedge clk) disable iff (!rstn)
        (ha.pop & ~ha.head_valid) == '0);

endmodule

//--- src/head_if.sv
`timescale 1ns/1ns
`include "sched_consts.svh"

// heads of all class queues toward the arbiter, pop strobes back
interface head_if
    import sched_pkg::*;
();

    logic [`NUM_CLASSES-1:0] head_valid;
    elem_t                   head [`NUM_CLASSES];
    logic [`NUM_CLASSES-1:0] full;

    // one-hot or zero
    logic [`NUM_CLASSES-1:0] pop;
    // overflow bit of the last dequeued element
    logic                    last_ovf;

    modport queue (output head_valid, output head, output full,
                   input pop, input last_ovf);

    modport arbiter (input head_valid, input head,
                     output pop, output last_ovf);

endinterface

//--- src/pause_cfg_regs.sv
`timescale 1ns/1ns
`include "sched_consts.svh"

// per-class pause enable and pause threshold
module pause_cfg_regs
    import sched_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    cfg_we,
    input  logic [`COS_W-1:0]       cfg_class,
    input  logic                    cfg_pause,
    input  prank_t                  cfg_pause_rank,
    output logic [`NUM_CLASSES-1:0] pause_en,
    output prank_t                  pause_rank [`NUM_CLASSES]
);

    // one class entry per write strobe
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            pause_en <= '0;
            for (int c = 0; c < `NUM_CLASSES; c++)
            begin
                pause_rank[c] <= '0;
            end
        end
        else if (cfg_we)
        begin
            pause_en[cfg_class]   <= cfg_pause;
            pause_rank[cfg_class] <= cfg_pause_rank;
        end
    end

endmodule

//--- src/pifo_sched_top.sv
`timescale 1ns/1ns
`include "sched_consts.svh"

// multi-class PIFO scheduler with per-class pause
module pifo_sched_top
    import sched_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    insert_en,
    input  elem_t                   in_elem,
    input  logic                    pop_en,
    input  logic                    cfg_we,
    input  logic [`COS_W-1:0]       cfg_class,
    input  logic                    cfg_pause,
    input  prank_t                  cfg_pause_rank,
    output logic                    deq_valid,
    output elem_t                   deq_elem,
    output logic [`NUM_CLASSES-1:0] class_full
);

    head_if hif ();

    logic [`NUM_CLASSES-1:0] ins_vec;
    logic [`NUM_CLASSES-1:0] pause_en;
    prank_t                  pause_rank [`NUM_CLASSES];

    // insert strobe steered by the element's class field
    assign ins_vec = insert_en ? (`NUM_CLASSES'(1) << in_elem.cos) : '0;

    for (genvar i = 0; i < `NUM_CLASSES; i++)
    begin : g_class
        class_pifo #(
            .CLASS_ID (i)
        ) u_queue (
            .clk      (clk),
            .rstn     (rstn),
            .ins      (ins_vec[i]),
            .ins_elem (in_elem),
            .hq       (hif.queue)
        );
    end

    pause_cfg_regs u_cfg (
        .clk            (clk),
        .rstn           (rstn),
        .cfg_we         (cfg_we),
        .cfg_class      (cfg_class),
        .cfg_pause      (cfg_pause),
        .cfg_pause_rank (cfg_pause_rank),
        .pause_en       (pause_en),
        .pause_rank     (pause_rank)
    );

    head_arbiter u_arb (
        .clk        (clk),
        .rstn       (rstn),
        .pop_en     (pop_en),
        .pause_en   (pause_en),
        .pause_rank (pause_rank),
        .ha         (hif.arbiter),
        .deq_valid  (deq_valid),
        .deq_elem   (deq_elem)
    );

    assign class_full = hif.full;

endmodule

//--- src/sched_consts.svh
`ifndef SCHED_CONSTS_SVH
`define SCHED_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// scheduler sizing
////////////////////////////////////////////////////////////////////////////

// traffic classes, one queue each
`define NUM_CLASSES 8
// entries per class queue
`define QUEUE_DEPTH 4
// occupancy count, 0 .. QUEUE_DEPTH
`define CNT_W 3

// element field widths
`define RANK_W 8
`define COS_W 3
`define GPFC_RANK_W 6
`define ADDR_W 12

`endif

//--- src/sched_pkg.sv
`include "sched_consts.svh"

package sched_pkg;

    // pause rank, carried in each element and held as a per-class threshold
    typedef logic [`GPFC_RANK_W-1:0] prank_t;

    // queue element, 30 bits, msb first
    typedef struct packed {
        logic                overflow;
        logic [`RANK_W-1:0]  rank;
        logic [`COS_W-1:0]   cos;
        prank_t              gpfc_rank;
        logic [`ADDR_W-1:0]  addr;
    } elem_t;

    ////////////////////////////////////////////////////////////////////////////
    // ordering rule
    ////////////////////////////////////////////////////////////////////////////

    // true when a is served no later than b
    // same overflow bit as the last dequeue beats a wrapped one, then rank
    function automatic logic elem_precedes(
        input elem_t a,
        input elem_t b,
        input logic  last_ovf
    );
        logic a_cur;
        logic b_cur;
        a_cur = (a.overflow == last_ovf);
        b_cur = (b.overflow == last_ovf);
        if (a_cur != b_cur)
        begin
            return a_cur;
        end
        return (a.rank <= b.rank);
    endfunction

endpackage

//--- verilog.f
+incdir+src
src/sched_pkg.sv
src/head_if.sv
src/class_pifo.sv
src/pause_cfg_regs.sv
src/head_arbiter.sv
src/pifo_sched_top.sv
dv/tb_pifo_sched.sv
